//--- source/sram_tester_pkg.sv
package sram_tester_pkg;

  // sram geometry, kept small so a sweep is short in simulation
  localparam int addr_bits = 6;
  localparam int data_bits = 16;

  // expected-data fifo
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_bits = $clog2(fifo_depth);

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [data_bits-1:0] data_t;

  typedef logic [fifo_ptr_bits-1:0] fifo_ptr_t;
  // one extra bit so a full fifo can be told from an empty one
  typedef logic [fifo_ptr_bits:0] fifo_count_t;

  // patterns in the order they are applied
  typedef enum logic [2:0] {
    pat_zeros,
    pat_ones,
    pat_five,
    pat_a,
    pat_addr
  } pattern_state_t;

  typedef enum logic [2:0] {
    st_start,
    st_write,
    st_write_wait,
    st_read,
    st_read_wait,
    st_done,
    st_halt
  } tester_state_t;

endpackage

//--- source/addr_iter.sv
module addr_iter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  inc,
  input  logic                  restart,
  output sram_tester_pkg::addr_t addr,
  output logic                  last
);

  sram_tester_pkg::addr_t count;

  // natural wrap to zero after the top address
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (restart) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

  assign addr = count;

  // top address is all ones
  assign last = &count;

endmodule

//--- source/pattern_gen.sv
module pattern_gen (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           restart,
  input  logic                           inc,
  input  sram_tester_pkg::addr_t         addr,
  output sram_tester_pkg::data_t         pattern,
  output logic                           done,
  output sram_tester_pkg::pattern_state_t state
);

  sram_tester_pkg::pattern_state_t next_state;

  always_comb begin
    case (state)
      sram_tester_pkg::pat_zeros: next_state = sram_tester_pkg::pat_ones;
      sram_tester_pkg::pat_ones:  next_state = sram_tester_pkg::pat_five;
      sram_tester_pkg::pat_five:  next_state = sram_tester_pkg::pat_a;
      sram_tester_pkg::pat_a:     next_state = sram_tester_pkg::pat_addr;
      default:                    next_state = sram_tester_pkg::pat_zeros;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sram_tester_pkg::pat_zeros;
    end else if (restart) begin
      state <= sram_tester_pkg::pat_zeros;
    end else if (inc) begin
      state <= next_state;
    end
  end

  // data word for the current pattern
  always_comb begin
    case (state)
      sram_tester_pkg::pat_zeros: pattern = '0;
      sram_tester_pkg::pat_ones:  pattern = '1;
      sram_tester_pkg::pat_five:  pattern = {(sram_tester_pkg::data_bits / 2){2'b01}};
      sram_tester_pkg::pat_a:     pattern = {(sram_tester_pkg::data_bits / 2){2'b10}};
      // address as data, zero extended
      sram_tester_pkg::pat_addr:  pattern = sram_tester_pkg::data_t'(addr);
      default:                    pattern = '0;
    endcase
  end

  // final pattern of the list
  assign done = (state == sram_tester_pkg::pat_addr);

endmodule

//--- source/expected_fifo.sv
module expected_fifo (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  sram_tester_pkg::data_t push_data,
  output sram_tester_pkg::data_t pop_data,
  output logic                  empty,
  output logic                  full
);

  sram_tester_pkg::data_t       mem [sram_tester_pkg::fifo_depth];
  sram_tester_pkg::fifo_ptr_t   wr_ptr;
  sram_tester_pkg::fifo_ptr_t   rd_ptr;
  sram_tester_pkg::fifo_count_t count;
  logic                         do_push;
  logic                         do_pop;

  // requests that cannot be served are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  assign pop_data = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == sram_tester_pkg::fifo_count_t'(sram_tester_pkg::fifo_depth));

endmodule

//--- source/axil_sram_ctrl.sv
module axil_sram_ctrl (
  input  logic                   clk,
  input  logic                   reset,

  // axi-lite write address and data
  input  sram_tester_pkg::addr_t awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  sram_tester_pkg::data_t wdata,
  input  logic                   wvalid,
  output logic                   wready,

  // write response, always okay
  output logic                   bvalid,
  input  logic                   bready,

  // read address and data
  input  sram_tester_pkg::addr_t araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output sram_tester_pkg::data_t rdata,
  output logic                   rvalid,
  input  logic                   rready,

  // asynchronous sram pins
  output sram_tester_pkg::addr_t sram_addr,
  output sram_tester_pkg::data_t sram_data_out,
  output logic                   sram_data_oe,
  input  sram_tester_pkg::data_t sram_data_in,
  output logic                   sram_we_n,
  output logic                   sram_oe_n,
  output logic                   sram_ce_n
);

  typedef enum logic [2:0] {
    c_idle,
    c_write,
    c_write_resp,
    c_read,
    c_read_resp
  } ctrl_state_t;

  ctrl_state_t            state;
  logic                   rd_accept;
  logic                   wr_accept;
  sram_tester_pkg::addr_t addr_q;
  sram_tester_pkg::data_t data_q;

  // reads win when both are offered
  assign arready   = (state == c_idle);
  assign rd_accept = arready && arvalid;
  assign wr_accept = (state == c_idle) && awvalid && wvalid && !arvalid;

  // aw and w only ever accepted together
  assign awready = wr_accept;
  assign wready  = wr_accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= c_idle;
    end else begin
      case (state)
        c_idle: begin
          if (rd_accept) begin
            state <= c_read;
          end else if (wr_accept) begin
            state <= c_write;
          end
        end
        c_write:      state <= c_write_resp;
        c_write_resp: if (bready) state <= c_idle;
        c_read:       state <= c_read_resp;
        c_read_resp:  if (rready) state <= c_idle;
        default:      state <= c_idle;
      endcase
    end
  end

  // address and write data held through the access
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      addr_q <= araddr;
    end else if (wr_accept) begin
      addr_q <= awaddr;
      data_q <= wdata;
    end
  end

  // sample the bus at the end of the read strobe
  always_ff @(posedge clk) begin
    if (state == c_read) rdata <= sram_data_in;
  end

  assign bvalid = (state == c_write_resp);
  assign rvalid = (state == c_read_resp);

  // strobes are low for exactly one cycle per access
  assign sram_addr     = addr_q;
  assign sram_data_out = data_q;
  assign sram_data_oe  = (state == c_write);
  assign sram_we_n     = (state != c_write);
  assign sram_oe_n     = (state != c_read);
  assign sram_ce_n     = !((state == c_write) || (state == c_read));

endmodule

//--- source/sram_tester.sv
module sram_tester (
  input  logic                            clk,
  input  logic                            reset,
  output logic                            test_done,
  output logic                            test_pass,
  output logic                            compare_valid,
  output sram_tester_pkg::pattern_state_t pattern_state,
  output sram_tester_pkg::data_t          prev_read_data,
  output sram_tester_pkg::data_t          prev_expected_data,
  output sram_tester_pkg::addr_t          iter_addr,
  output sram_tester_pkg::addr_t          sram_addr,
  output sram_tester_pkg::data_t          sram_data_out,
  output logic                            sram_data_oe,
  input  sram_tester_pkg::data_t          sram_data_in,
  output logic                            sram_we_n,
  output logic                            sram_oe_n,
  output logic                            sram_ce_n
);

  // axi-lite between sequencer and controller
  sram_tester_pkg::addr_t awaddr;
  logic                   awvalid;
  logic                   awready;
  sram_tester_pkg::data_t wdata;
  logic                   wvalid;
  logic                   wready;
  logic                   bvalid;
  logic                   bready;
  sram_tester_pkg::addr_t araddr;
  logic                   arvalid;
  logic                   arready;
  sram_tester_pkg::data_t rdata;
  logic                   rvalid;
  logic                   rready;

  sram_tester_pkg::tester_state_t state;
  sram_tester_pkg::tester_state_t next_state;

  logic                   iter_inc;
  logic                   iter_last;
  logic                   sweep_restart;
  logic                   pattern_inc;
  sram_tester_pkg::data_t pattern;
  logic                   pattern_done;
  logic                   fifo_push;
  logic                   fifo_pop;
  logic                   fifo_empty;
  logic                   fifo_full;
  sram_tester_pkg::data_t fifo_head;
  logic                   last_op;
  logic                   rd_hs;
  logic                   mismatch;

  addr_iter u_addr_iter (
    .clk    (clk),
    .reset  (reset),
    .inc    (iter_inc),
    .restart(sweep_restart),
    .addr   (iter_addr),
    .last   (iter_last)
  );

  pattern_gen u_pattern_gen (
    .clk    (clk),
    .reset  (reset),
    .restart(sweep_restart),
    .inc    (pattern_inc),
    .addr   (iter_addr),
    .pattern(pattern),
    .done   (pattern_done),
    .state  (pattern_state)
  );

  // expected words wait here until their read data returns
  expected_fifo u_expected_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (fifo_push),
    .pop      (fifo_pop),
    .push_data(pattern),
    .pop_data (fifo_head),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  axil_sram_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rready       (rready),
    .sram_addr    (sram_addr),
    .sram_data_out(sram_data_out),
    .sram_data_oe (sram_data_oe),
    .sram_data_in (sram_data_in),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  // the tester never applies back-pressure
  assign bready = 1'b1;
  assign rready = 1'b1;

  assign sweep_restart = (state == sram_tester_pkg::st_start) ||
                         (state == sram_tester_pkg::st_done);
  assign test_done     = (state == sram_tester_pkg::st_done);

  always_comb begin
    next_state  = state;
    iter_inc    = 1'b0;
    pattern_inc = 1'b0;
    fifo_push   = 1'b0;
    case (state)
      sram_tester_pkg::st_start: next_state = sram_tester_pkg::st_write;
      sram_tester_pkg::st_write: begin
        iter_inc   = 1'b1;
        next_state = sram_tester_pkg::st_write_wait;
      end
      sram_tester_pkg::st_write_wait: begin
        if (bvalid && bready) begin
          next_state = last_op ? sram_tester_pkg::st_read : sram_tester_pkg::st_write;
        end
      end
      sram_tester_pkg::st_read: begin
        if (!fifo_full) begin
          iter_inc   = 1'b1;
          fifo_push  = 1'b1;
          next_state = sram_tester_pkg::st_read_wait;
        end
      end
      sram_tester_pkg::st_read_wait: begin
        if (!last_op) begin
          if (arvalid && arready) next_state = sram_tester_pkg::st_read;
        end else if (!arvalid && fifo_empty && !compare_valid) begin
          // last read of the pattern has been compared
          if (pattern_done) begin
            next_state = sram_tester_pkg::st_done;
          end else begin
            pattern_inc = 1'b1;
            next_state  = sram_tester_pkg::st_write;
          end
        end
      end
      sram_tester_pkg::st_done: next_state = sram_tester_pkg::st_write;
      sram_tester_pkg::st_halt: next_state = sram_tester_pkg::st_halt;
      default:                  next_state = sram_tester_pkg::st_halt;
    endcase
    // a failed compare stops the test for good
    if (mismatch) next_state = sram_tester_pkg::st_halt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sram_tester_pkg::st_start;
    end else begin
      state <= next_state;
    end
  end

  // remembers whether the address just issued was the top one
  always_ff @(posedge clk) begin
    if (reset) begin
      last_op <= 1'b0;
    end else if (iter_inc) begin
      last_op <= iter_last;
    end
  end

  always_ff @(posedge clk) begin
    if (state == sram_tester_pkg::st_write) begin
      awaddr <= iter_addr;
      wdata  <= pattern;
    end
    if (fifo_push) araddr <= iter_addr;
  end

  // valids rise one cycle after the issuing state, drop on their handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
    end else begin
      if (state == sram_tester_pkg::st_write) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (awready) awvalid <= 1'b0;
        if (wready) wvalid <= 1'b0;
      end
      if (fifo_push) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
    end
  end

  assign rd_hs    = rvalid && rready;
  assign fifo_pop = rd_hs;
  assign mismatch = compare_valid && (prev_read_data != prev_expected_data);

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      prev_read_data     <= rdata;
      prev_expected_data <= fifo_head;
    end
  end

  // reads still in flight after a halt are not compared
  always_ff @(posedge clk) begin
    if (reset) begin
      compare_valid <= 1'b0;
      test_pass     <= 1'b1;
    end else begin
      compare_valid <= rd_hs && (state != sram_tester_pkg::st_halt);
      if (mismatch) test_pass <= 1'b0;
    end
  end

endmodule

//--- dv/sram_model.sv
module sram_model (
  input  sram_tester_pkg::addr_t                      addr,
  // write data driven by the tester
  input  sram_tester_pkg::data_t                      data_in,
  input  logic                                        data_oe,
  // read data back to the tester
  output sram_tester_pkg::data_t                      data_out,
  input  logic                                        we_n,
  input  logic                                        oe_n,
  input  logic                                        ce_n,
  input  logic                                        fault_en,
  input  sram_tester_pkg::addr_t                      fault_addr,
  input  logic [$clog2(sram_tester_pkg::data_bits)-1:0] fault_bit,
  input  logic                                        fault_value
);

  sram_tester_pkg::data_t mem [1 << sram_tester_pkg::addr_bits];
  sram_tester_pkg::data_t word;

  // power-up contents differ per address so a lost write shows up
  initial begin
    for (int i = 0; i < (1 << sram_tester_pkg::addr_bits); i++) begin
      mem[i] = sram_tester_pkg::data_t'((i * 1031) ^ 32'h0000_c35a);
    end
  end

  // level sensitive write while both strobes are low
  always @(addr or data_in or data_oe or we_n or ce_n) begin
    if (!ce_n && !we_n && data_oe) mem[addr] = data_in;
  end

  // stuck bit only shows on the read path
  always_comb begin
    word = mem[addr];
    if (fault_en && (addr == fault_addr)) word[fault_bit] = fault_value;
  end

  assign data_out = (!ce_n && !oe_n) ? word : '0;

endmodule

//--- dv/sram_tester_asserts.sv
module sram_tester_asserts (
  input logic clk,
  input logic reset,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic arvalid,
  input logic arready,
  input logic sram_we_n,
  input logic sram_oe_n,
  input logic fifo_push,
  input logic fifo_pop,
  input logic fifo_full,
  input logic fifo_empty,
  input logic test_pass
);

  logic [2:0] stalled;
  logic [2:0] valids;
  logic       hold_failed = 1'b0;
  logic       strobe_failed = 1'b0;
  logic       fifo_failed = 1'b0;
  logic       pass_failed = 1'b0;
  logic       any_failed;

  // channel order is aw, w, ar
  assign stalled = {awvalid && !awready, wvalid && !wready, arvalid && !arready};
  assign valids  = {awvalid, wvalid, arvalid};

  assign any_failed = hold_failed || strobe_failed || fifo_failed || pass_failed;

  valid_held: assert property (@(posedge clk) disable iff (reset)
    ($past(stalled) & ~valids) == 3'b000)
    else begin
      hold_failed = 1'b1;
      $error("valid dropped before ready on aw, w or ar");
    end

  strobes_apart: assert property (@(posedge clk) disable iff (reset)
    sram_we_n || sram_oe_n)
    else begin
      strobe_failed = 1'b1;
      $error("sram we_n and oe_n low in the same cycle");
    end

  fifo_bounds: assert property (@(posedge clk) disable iff (reset)
    !(fifo_push && fifo_full) && !(fifo_pop && fifo_empty))
    else begin
      fifo_failed = 1'b1;
      $error("expected fifo pushed while full or popped while empty");
    end

  // once a mismatch is seen the tester stays failed
  pass_sticky: assert property (@(posedge clk) disable iff (reset)
    !test_pass |=> !test_pass)
    else begin
      pass_failed = 1'b1;
      $error("test_pass rose again after falling");
    end

endmodule

//--- dv/sram_tester_tb.sv
module sram_tester_tb;

  localparam int words = 1 << sram_tester_pkg::addr_bits;
  localparam int patterns = 5;
  localparam int sweep_compares = words * patterns;
  // a write step takes 4 cycles, a read issue up to 3
  localparam int sweep_cycles = sweep_compares * (4 + 3);
  localparam int timeout_cycles = 3 * sweep_cycles + sweep_cycles / 2;
  localparam int sweeps_checked = 2;

  typedef logic [$clog2(sram_tester_pkg::data_bits)-1:0] bit_index_t;

  logic                            clk;
  logic                            reset;
  logic                            test_done;
  logic                            test_pass;
  logic                            compare_valid;
  sram_tester_pkg::pattern_state_t pattern_state;
  sram_tester_pkg::data_t          prev_read_data;
  sram_tester_pkg::data_t          prev_expected_data;
  sram_tester_pkg::addr_t          iter_addr;
  sram_tester_pkg::addr_t          sram_addr;
  sram_tester_pkg::data_t          sram_data_out;
  logic                            sram_data_oe;
  sram_tester_pkg::data_t          sram_data_in;
  logic                            sram_we_n;
  logic                            sram_oe_n;
  logic                            sram_ce_n;

  logic                            fault_en;
  sram_tester_pkg::addr_t          fault_addr;
  bit_index_t                      fault_bit;
  logic                            fault_value;
  int                              seed;

  sram_tester DUT (.*);

  sram_model u_sram (
    .addr       (sram_addr),
    .data_in    (sram_data_out),
    .data_oe    (sram_data_oe),
    .data_out   (sram_data_in),
    .we_n       (sram_we_n),
    .oe_n       (sram_oe_n),
    .ce_n       (sram_ce_n),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_bit  (fault_bit),
    .fault_value(fault_value)
  );

  bind sram_tester sram_tester_asserts u_asserts (.*);

  always #50 clk = ~clk;

  // reference pattern list, in the order the tester applies it
  function automatic sram_tester_pkg::data_t pattern_word(int pat, int addr);
    case (pat)
      0:       return '0;
      1:       return '1;
      2:       return 16'h5555;
      3:       return 16'haaaa;
      default: return sram_tester_pkg::data_t'(addr);
    endcase
  endfunction

  function automatic sram_tester_pkg::pattern_state_t pattern_name(int pat);
    case (pat)
      0:       return sram_tester_pkg::pat_zeros;
      1:       return sram_tester_pkg::pat_ones;
      2:       return sram_tester_pkg::pat_five;
      3:       return sram_tester_pkg::pat_a;
      default: return sram_tester_pkg::pat_addr;
    endcase
  endfunction

  // index of the first compare that sees the stuck bit, -1 if none
  function automatic int first_failing_compare();
    sram_tester_pkg::data_t word;
    for (int p = 0; p < patterns; p++) begin
      word = pattern_word(p, int'(fault_addr));
      if (word[fault_bit] != fault_value) return p * words + int'(fault_addr);
    end
    return -1;
  endfunction

  task automatic stop_on_failure(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopping after a failed check");
  endtask

  task automatic check_data(string name, sram_tester_pkg::data_t expected,
                            sram_tester_pkg::data_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_addr(string name, sram_tester_pkg::addr_t expected,
                            sram_tester_pkg::addr_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAIL %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_state(string name, sram_tester_pkg::pattern_state_t expected,
                             sram_tester_pkg::pattern_state_t actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAIL %s: expected %s, actual %s", name,
                                expected.name(), actual.name()));
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      stop_on_failure($sformatf("FAIL %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    stop_on_failure($sformatf("watchdog: no result after %0d cycles, the tester seems hung",
                              timeout_cycles));
  end

  initial begin
    sram_tester_pkg::data_t faulty_word;
    int model_addr;
    int model_pat;
    int compares;
    int sweeps;
    int fail_index;
    int n;
    logic finished;

    clk   = 1'b0;
    reset = 1'b1;
    seed  = 52;
    fault_en    = ($random(seed) % 2) != 0;
    fault_addr  = sram_tester_pkg::addr_t'($random(seed));
    fault_bit   = bit_index_t'($random(seed));
    fault_value = ($random(seed) % 2) != 0;
    fail_index  = fault_en ? first_failing_compare() : -1;
    if (fault_en) begin
      $display("stuck bit %0d at %0d on address %0d", fault_bit, fault_value, fault_addr);
    end
    model_addr = 0;
    model_pat  = 0;
    compares   = 0;
    sweeps     = 0;
    finished   = 1'b0;

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("test_pass after reset", 1'b1, test_pass);
    check_flag("test_done after reset", 1'b0, test_done);
    check_flag("compare_valid after reset", 1'b0, compare_valid);
    check_addr("iter_addr after reset", '0, iter_addr);
    // sram idle with the bus released
    check_flag("sram_ce_n after reset", 1'b1, sram_ce_n);
    check_flag("sram_we_n after reset", 1'b1, sram_we_n);
    check_flag("sram_oe_n after reset", 1'b1, sram_oe_n);
    check_flag("sram_data_oe after reset", 1'b0, sram_data_oe);

    while (!finished) begin
      @(negedge clk);
      check_flag("test_pass before any mismatch", 1'b1, test_pass);
      if (test_done) begin
        check_flag("test_done only after a full sweep", compares == sweep_compares, test_done);
        // every address walked, so the iterator is back at zero
        check_addr("iter_addr at end of sweep", '0, iter_addr);
        compares = 0;
        sweeps++;
      end
      if (compare_valid) begin
        if (compares == sweep_compares) check_flag("test_done at end of sweep", 1'b1, 1'b0);
        if (sweeps == sweeps_checked) finished = 1'b1;
        check_state("pattern state", pattern_name(model_pat), pattern_state);
        check_data($sformatf("expected word, pattern %0d addr %0d", model_pat, model_addr),
                   pattern_word(model_pat, model_addr), prev_expected_data);
        n = model_pat * words + model_addr;
        faulty_word = pattern_word(model_pat, model_addr);
        if (n == fail_index) begin
          // this read returns the stuck bit
          faulty_word[fault_bit] = fault_value;
          finished = 1'b1;
        end
        check_data($sformatf("read data, pattern %0d addr %0d", model_pat, model_addr),
                   faulty_word, prev_read_data);
        model_addr++;
        if (model_addr == words) begin
          model_addr = 0;
          model_pat  = (model_pat + 1) % patterns;
        end
        compares++;
      end
    end

    if (fail_index >= 0) begin
      @(negedge clk);
      check_flag("test_pass after mismatch", 1'b0, test_pass);
      // several read times with no further compare
      repeat (4 * words) begin
        @(negedge clk);
        check_flag("compare_valid after halt", 1'b0, compare_valid);
        check_flag("test_pass after halt", 1'b0, test_pass);
      end
    end

    if (DUT.u_asserts.any_failed) begin
      stop_on_failure("a bound protocol assertion failed during the run");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- build.f
source/sram_tester_pkg.sv
source/addr_iter.sv
source/pattern_gen.sv
source/expected_fifo.sv
source/axil_sram_ctrl.sv
source/sram_tester.sv
dv/sram_model.sv
dv/sram_tester_asserts.sv
dv/sram_tester_tb.sv

//--- run.sh
#!/bin/sh
# builds the sram tester testbench with verilator and runs it once
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module sram_tester_tb -f build.f \
  --Mdir obj_dir -o sram_tester_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sram_tester_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
